// File: compile.f
source/tdc_time_pkg.sv
source/tdc_stream_pkg.sv
source/tdc_hit_if.sv
source/tdc_result_if.sv
source/tdc_window_ctrl.sv
source/tdc_hit_slot.sv
source/tdc_out_stream.sv
source/tdc_top.sv
bench/tdc_tb.sv

// File: Bender.yml
package:
  name: tdc_front_end

sources:
  - files:
      - source/tdc_time_pkg.sv
      - source/tdc_stream_pkg.sv
      - source/tdc_hit_if.sv
      - source/tdc_result_if.sv
      - source/tdc_window_ctrl.sv
      - source/tdc_hit_slot.sv
      - source/tdc_out_stream.sv
      - source/tdc_top.sv
  - target: test
    files:
      - bench/tdc_tb.sv

// File: bench/tdc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_tb;
    import tdc_time_pkg::*;
    import tdc_stream_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       start_i;
    logic       trigger_i;
    phase_t     phase_i;
    tof_t       range_i;
    spad_t      spad_i;
    logic       m_ready_i;
    tof_t       m_data_o;
    intensity_t m_int_o;
    hit_cnt_t   m_num_o;
    logic       m_last_o;
    logic       m_valid_o;
    logic       busy_o;

    int unsigned cycles;
    int unsigned cycle_limit = 40;     // reset plus margin, frames add their own
    int          n_checks    = 0;
    int          n_errors    = 0;
    logic [31:0] rng         = 32'hea16;

    // triggers of the next frame, in edge order
    int          trig_edge  [$];
    phase_t      trig_phase [$];
    spad_t       trig_spad  [$];
    int          busy_start_edge = -1;

    tof_t        exp_tof [$];
    intensity_t  exp_int [$];
    hit_cnt_t    exp_num;

    tdc_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start_i),
        .trigger_i (trigger_i),
        .phase_i   (phase_i),
        .range_i   (range_i),
        .spad_i    (spad_i),
        .m_ready_i (m_ready_i),
        .m_data_o  (m_data_o),
        .m_int_o   (m_int_o),
        .m_num_o   (m_num_o),
        .m_last_o  (m_last_o),
        .m_valid_o (m_valid_o),
        .busy_o    (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the frame did not finish within %0d cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------
    task automatic check_tof(input string name, input tof_t got, input tof_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            n_errors++;
        end
    endtask

    task automatic check_int(input string name, input intensity_t got, input intensity_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            n_errors++;
        end
    endtask

    task automatic check_num(input string name, input hit_cnt_t got, input hit_cnt_t exp);
        n_checks++;
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            n_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            n_errors++;
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic fine_t fine_code(input phase_t ph);
        int n;
        n = 0;
        while (n < PHASE_W && ph[n] == 1'b1) begin
            n++;
        end
        return (n > 31) ? fine_t'(31) : fine_t'(n);
    endfunction

    function automatic intensity_t lit_count(input spad_t en);
        int n;
        n = $countones(en);
        return (n > 15) ? intensity_t'(15) : intensity_t'(n);
    endfunction

    function automatic tof_t expect_tof(input int coarse, input phase_t stop_ph,
                                        input phase_t start_ph, input tof_t range);
        int t;
        t = (coarse * 32 + int'(fine_code(stop_ph)) - int'(fine_code(start_ph))) & 32'h7FFF;
        return (t > int'(range)) ? TOF_OVERFLOW : tof_t'(t);
    endfunction

    function automatic phase_t thermo(input int k);
        return phase_t'((64'd1 << k) - 64'd1);     // k ones from bit 0
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ----------------------------------------------------------------------
    // stimulus and collection
    // ----------------------------------------------------------------------
    task automatic add_trigger(input int at_edge, input phase_t ph, input spad_t en);
        trig_edge.push_back(at_edge);
        trig_phase.push_back(ph);
        trig_spad.push_back(en);
    endtask

    task automatic drive_trigger(input int k);
        trigger_i = 1'b0;
        spad_i    = '0;
        if (k != 0) begin
            phase_i = thermo(k % 33);              // filler between hits
        end
        foreach (trig_edge[i]) begin
            if (trig_edge[i] == k) begin
                trigger_i = 1'b1;
                phase_i   = trig_phase[i];
                spad_i    = trig_spad[i];
            end
        end
    endtask

    task automatic collect_frame(input logic bp);
        int         beats;
        int         total;
        logic       rdy;
        logic       held;
        tof_t       held_tof;
        intensity_t held_int;
        hit_cnt_t   held_num;
        logic       held_last;
        beats = 0;
        total = exp_tof.size();
        held  = 1'b0;
        while (beats < total) begin
            @(negedge clk);
            if (held) begin                        // stalled beat must not move
                check_bit("m_valid_o held", m_valid_o, 1'b1);
                check_tof("m_data_o held", m_data_o, held_tof);
                check_int("m_int_o held", m_int_o, held_int);
                check_num("m_num_o held", m_num_o, held_num);
                check_bit("m_last_o held", m_last_o, held_last);
            end
            rdy = 1'b1;
            if (bp) begin
                rng = xorshift(rng);
                rdy = rng[0];
            end
            m_ready_i = rdy;
            held      = m_valid_o & ~rdy;
            held_tof  = m_data_o;
            held_int  = m_int_o;
            held_num  = m_num_o;
            held_last = m_last_o;
            if (m_valid_o && rdy) begin            // transfers at the next rising edge
                check_tof("m_data_o", m_data_o, exp_tof[beats]);
                check_int("m_int_o", m_int_o, exp_int[beats]);
                check_num("m_num_o", m_num_o, exp_num);
                check_bit("m_last_o", m_last_o, beats == total - 1);
                beats++;
            end
        end
        @(negedge clk);
        m_ready_i = 1'b1;
        check_bit("m_valid_o", m_valid_o, 1'b0);   // no extra beat
        check_bit("busy_o", busy_o, 1'b1);
        @(negedge clk);
        check_bit("busy_o", busy_o, 1'b0);
    endtask

    task automatic run_frame(input tof_t range, input phase_t start_ph, input logic bp);
        int coarse_end;
        int hits;
        coarse_end   = int'(range[TOF_W-1:FINE_W]);
        cycle_limit += coarse_end + 200;
        exp_tof.delete();
        exp_int.delete();
        hits = 0;
        foreach (trig_edge[i]) begin
            if (trig_edge[i] >= 1 && trig_edge[i] <= coarse_end && hits < 3) begin
                exp_tof.push_back(expect_tof(trig_edge[i] - 1, trig_phase[i], start_ph, range));
                exp_int.push_back(lit_count(trig_spad[i]));
                hits++;
            end
        end
        exp_num = hit_cnt_t'(hits);
        if (hits == 0) begin
            exp_tof.push_back(TOF_OVERFLOW);
            exp_int.push_back('0);
        end
        @(negedge clk);
        m_ready_i = 1'b0;
        start_i   = 1'b1;
        range_i   = range;
        phase_i   = start_ph;
        drive_trigger(0);
        for (int k = 1; k <= coarse_end + 2; k++) begin
            @(negedge clk);
            start_i = (k == busy_start_edge);
            range_i = ~range;                      // only the latched range counts
            drive_trigger(k);
        end
        @(negedge clk);
        start_i   = 1'b0;
        trigger_i = 1'b0;
        collect_frame(bp);
        trig_edge.delete();
        trig_phase.delete();
        trig_spad.delete();
        busy_start_edge = -1;
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------
    task automatic test_no_hit();
        add_trigger(0, thermo(4), 16'hFFFF);       // same cycle as start
        add_trigger(11, thermo(9), 16'h00FF);      // window close edge
        run_frame(15'h0140, thermo(4), 1'b0);
    endtask

    task automatic test_one_hit();
        add_trigger(7, thermo(20), 16'hA5A5);
        run_frame(15'h0200, thermo(6), 1'b0);
    endtask

    task automatic test_three_hits();
        add_trigger(1, thermo(31), 16'h0001);
        add_trigger(9, thermo(32), 16'hFFFF);      // fine and intensity saturate
        add_trigger(15, thermo(0), 16'h0F0F);
        add_trigger(22, thermo(12), 16'h3333);     // fourth, dropped
        run_frame(15'h0300, thermo(10), 1'b0);
    endtask

    task automatic test_clamp();
        add_trigger(1, thermo(12), 16'h0010);      // stop below start at coarse 0
        add_trigger(2, thermo(3), 16'h0300);
        add_trigger(8, thermo(31), 16'h7000);      // last edge of the window
        run_frame(15'h0105, thermo(20), 1'b0);
    endtask

    task automatic test_backpressure();
        add_trigger(3, thermo(17), 16'h1234);
        add_trigger(4, thermo(5), 16'h8001);
        add_trigger(18, thermo(29), 16'h7FFF);
        run_frame(15'h0280, thermo(0), 1'b1);
        add_trigger(5, thermo(2), 16'h0000);
        add_trigger(14, thermo(32), 16'hF000);
        run_frame(15'h01E0, thermo(31), 1'b1);
        run_frame(15'h0060, thermo(7), 1'b1);      // empty frame under stall
    endtask

    task automatic test_start_busy();
        busy_start_edge = 5;
        add_trigger(2, thermo(15), 16'h0003);
        add_trigger(10, thermo(1), 16'hC000);
        run_frame(15'h0180, thermo(8), 1'b0);
    endtask

    initial begin
        rst_n     = 1'b0;
        start_i   = 1'b0;
        trigger_i = 1'b0;
        phase_i   = '0;
        range_i   = RANGE_RESET;
        spad_i    = '0;
        m_ready_i = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("m_valid_o", m_valid_o, 1'b0);
        check_bit("m_last_o", m_last_o, 1'b0);
        check_bit("busy_o", busy_o, 1'b0);
        test_no_hit();
        test_one_hit();
        test_three_hits();
        test_clamp();
        test_backpressure();
        test_start_busy();
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/tdc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start_i,
    input  logic                       trigger_i,
    input  tdc_time_pkg::phase_t       phase_i,
    input  tdc_time_pkg::tof_t         range_i,
    input  tdc_stream_pkg::spad_t      spad_i,
    input  logic                       m_ready_i,
    output tdc_time_pkg::tof_t         m_data_o,
    output tdc_stream_pkg::intensity_t m_int_o,
    output tdc_stream_pkg::hit_cnt_t   m_num_o,
    output logic                       m_last_o,
    output logic                       m_valid_o,
    output logic                       busy_o
);
    import tdc_time_pkg::*;
    import tdc_stream_pkg::*;

    tof_t     range_lat;        // range held for the frame
    logic     window_done;
    hit_cnt_t hit_count;
    logic     frame_done;

    tdc_hit_if    hit_bus [N_SLOTS] ();
    tdc_result_if res_bus [N_SLOTS] ();

    // ----------------------------------------------------------------------
    // window control, slots, streamer
    // ----------------------------------------------------------------------
    tdc_window_ctrl u_window_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .trigger_i     (trigger_i),
        .phase_i       (phase_i),
        .range_i       (range_i),
        .spad_i        (spad_i),
        .frame_done_i  (frame_done),
        .hit_o         (hit_bus),
        .range_o       (range_lat),
        .window_done_o (window_done),
        .hit_count_o   (hit_count),
        .busy_o        (busy_o)
    );

    for (genvar g = 0; g < N_SLOTS; g++) begin : g_slot
        tdc_hit_slot u_slot (
            .clk     (clk),
            .rst_n   (rst_n),
            .range_i (range_lat),
            .hit     (hit_bus[g]),
            .res     (res_bus[g])
        );
    end

    tdc_out_stream u_out_stream (
        .clk           (clk),
        .rst_n         (rst_n),
        .window_done_i (window_done),
        .hit_count_i   (hit_count),
        .res           (res_bus),
        .m_ready_i     (m_ready_i),
        .m_data_o      (m_data_o),
        .m_int_o       (m_int_o),
        .m_num_o       (m_num_o),
        .m_last_o      (m_last_o),
        .m_valid_o     (m_valid_o),
        .frame_done_o  (frame_done)
    );

endmodule

`default_nettype wire

// File: source/tdc_out_stream.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_out_stream (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       window_done_i,
    input  tdc_stream_pkg::hit_cnt_t   hit_count_i,
    tdc_result_if.snk                  res [tdc_stream_pkg::N_SLOTS],
    input  logic                       m_ready_i,
    output tdc_time_pkg::tof_t         m_data_o,
    output tdc_stream_pkg::intensity_t m_int_o,
    output tdc_stream_pkg::hit_cnt_t   m_num_o,
    output logic                       m_last_o,
    output logic                       m_valid_o,
    output logic                       frame_done_o
);
    import tdc_time_pkg::*;
    import tdc_stream_pkg::*;

    stream_state_e      state_q;
    hit_cnt_t           rec_idx_q;      // slot currently on the stream
    hit_cnt_t           rec_sel;        // slot loaded at this edge
    logic [N_SLOTS-1:0] slot_vld;
    logic [N_SLOTS-1:0] slot_used;
    logic [N_SLOTS-1:0] clr_q;
    tof_t               slot_tof [N_SLOTS];
    intensity_t         slot_int [N_SLOTS];
    logic               all_ready;
    logic               beat_acc;
    logic               load_rec;
    logic               last_rec;

    for (genvar g = 0; g < N_SLOTS; g++) begin : g_res
        assign slot_vld[g]  = res[g].valid;
        assign slot_tof[g]  = res[g].tof;
        assign slot_int[g]  = res[g].intensity;
        assign slot_used[g] = hit_count_i > hit_cnt_t'(g);
        assign res[g].clear = clr_q[g];
    end

    assign all_ready = &(slot_vld | ~slot_used);        // true at once for an empty frame
    assign beat_acc  = m_valid_o & m_ready_i;

    // next record goes out when waiting ends or a middle beat is taken
    assign load_rec = ((state_q == WAIT) & all_ready) | (beat_acc & ~m_last_o);
    assign rec_sel  = (state_q == WAIT) ? '0 : rec_idx_q + 1'b1;
    assign last_rec = (hit_count_i == '0) | (rec_sel == hit_count_i - 1'b1);

    // ----------------------------------------------------------------------
    // frame sequencing
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= IDLE;
            rec_idx_q <= '0;
            m_valid_o <= 1'b0;
            m_last_o  <= 1'b0;
            clr_q     <= '0;
        end else begin
            clr_q <= '0;
            case (state_q)
                IDLE: begin
                    if (window_done_i) begin
                        state_q <= WAIT;
                    end
                end
                WAIT: begin
                    if (all_ready) begin
                        state_q   <= SEND;
                        m_valid_o <= 1'b1;
                        m_last_o  <= last_rec;
                        rec_idx_q <= rec_sel;
                    end
                end
                SEND: begin
                    if (beat_acc) begin
                        if (slot_used[rec_idx_q]) begin
                            clr_q[rec_idx_q] <= 1'b1;   // release slot
                        end
                        if (m_last_o) begin
                            state_q   <= DONE;
                            m_valid_o <= 1'b0;
                            m_last_o  <= 1'b0;
                        end else begin
                            m_last_o  <= last_rec;
                            rec_idx_q <= rec_sel;
                        end
                    end
                end
                DONE: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // record payload, held until its beat is taken
    always_ff @(posedge clk) begin
        if (load_rec) begin
            m_num_o <= hit_count_i;
            if (hit_count_i == '0) begin
                m_data_o <= TOF_OVERFLOW;
                m_int_o  <= '0;
            end else begin
                m_data_o <= slot_tof[rec_sel];
                m_int_o  <= slot_int[rec_sel];
            end
        end
    end

    assign frame_done_o = (state_q == DONE);

endmodule

`default_nettype wire

// File: source/tdc_hit_slot.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_hit_slot (
    input  logic               clk,
    input  logic               rst_n,
    input  tdc_time_pkg::tof_t range_i,
    tdc_hit_if.snk             hit,
    tdc_result_if.src          res
);
    import tdc_time_pkg::*;
    import tdc_stream_pkg::*;

    // run of ones from bit 0, capped at 31
    function automatic fine_t fine_decode(input phase_t ph);
        logic [FINE_W:0] n;
        logic            run;
        n   = '0;
        run = 1'b1;
        for (int i = 0; i < PHASE_W; i++) begin
            run = run & ph[i];
            n   = n + (FINE_W+1)'(run);
        end
        fine_decode = n[FINE_W] ? '1 : n[FINE_W-1:0];
    endfunction

    function automatic intensity_t spad_count(input spad_t en);
        logic [INT_W:0] n;
        n = '0;
        for (int i = 0; i < SPAD_N; i++) begin
            n = n + (INT_W+1)'(en[i]);
        end
        spad_count = n[INT_W] ? '1 : n[INT_W-1:0];   // all 16 lit reads 15
    endfunction

    logic       s1_vld_q;
    fine_t      s1_start_q;
    fine_t      s1_stop_q;
    coarse_t    s1_coarse_q;
    intensity_t s1_int_q;

    tof_t       tof_raw;
    logic       res_vld_q;
    tof_t       res_tof_q;
    intensity_t res_int_q;

    // ----------------------------------------------------------------------
    // stage 1, fine decode and popcount
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld_q <= 1'b0;
        end else begin
            s1_vld_q <= hit.load;
        end
    end

    always_ff @(posedge clk) begin
        if (hit.load) begin
            s1_start_q  <= fine_decode(hit.start_phase);
            s1_stop_q   <= fine_decode(hit.stop_phase);
            s1_coarse_q <= hit.coarse;
            s1_int_q    <= spad_count(hit.spad);
        end
    end

    // ----------------------------------------------------------------------
    // stage 2, time of flight and range clamp
    // ----------------------------------------------------------------------
    assign tof_raw = {s1_coarse_q, s1_stop_q} - tof_t'(s1_start_q);   // wraps mod 2^15

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_vld_q <= 1'b0;
        end else if (s1_vld_q) begin
            res_vld_q <= 1'b1;
        end else if (res.clear) begin
            res_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_vld_q) begin
            res_tof_q <= (tof_raw > range_i) ? TOF_OVERFLOW : tof_raw;
            res_int_q <= s1_int_q;
        end
    end

    assign res.valid     = res_vld_q;
    assign res.tof       = res_tof_q;
    assign res.intensity = res_int_q;

endmodule

`default_nettype wire

// File: source/tdc_window_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tdc_window_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_i,
    input  logic                     trigger_i,
    input  tdc_time_pkg::phase_t     phase_i,
    input  tdc_time_pkg::tof_t       range_i,
    input  tdc_stream_pkg::spad_t    spad_i,
    input  logic                     frame_done_i,
    tdc_hit_if.src                   hit_o [tdc_stream_pkg::N_SLOTS],
    output tdc_time_pkg::tof_t       range_o,
    output logic                     window_done_o,
    output tdc_stream_pkg::hit_cnt_t hit_count_o,
    output logic                     busy_o
);
    import tdc_time_pkg::*;
    import tdc_stream_pkg::*;

    logic     busy_q;
    logic     win_open_q;
    logic     win_done_q;
    coarse_t  coarse_q;
    tof_t     range_q;
    phase_t   start_phase_q;
    hit_cnt_t hit_cnt_q;

    // capture registers, one entry per slot
    coarse_t  cap_coarse [N_SLOTS];
    phase_t   cap_phase  [N_SLOTS];
    spad_t    cap_spad   [N_SLOTS];

    logic     start_ok;
    logic     win_close;
    logic     hit_ok;

    assign start_ok  = start_i & ~busy_q;                       // starts while busy are dropped
    assign win_close = win_open_q & (coarse_q >= range_q[TOF_W-1:FINE_W]);
    assign hit_ok    = win_open_q & ~win_close & trigger_i
                     & (hit_cnt_q < hit_cnt_t'(N_SLOTS));

    // ----------------------------------------------------------------------
    // busy flag, window and coarse counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            win_open_q <= 1'b0;
            win_done_q <= 1'b0;
            coarse_q   <= '0;
            range_q    <= RANGE_RESET;
        end else begin
            win_done_q <= win_close;
            if (start_ok) begin
                busy_q     <= 1'b1;
                win_open_q <= 1'b1;
                coarse_q   <= '0;
                range_q    <= range_i;
            end else begin
                if (frame_done_i) begin
                    busy_q <= 1'b0;     // frame fully streamed
                end
                if (win_close) begin
                    win_open_q <= 1'b0;
                end else if (win_open_q) begin
                    coarse_q <= coarse_q + 1'b1;
                end
            end
        end
    end

    // hit counter, cleared per frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_cnt_q <= '0;
        end else if (start_ok || frame_done_i) begin
            hit_cnt_q <= '0;
        end else if (hit_ok) begin
            hit_cnt_q <= hit_cnt_q + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // phase and hit capture
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start_ok) begin
            start_phase_q <= phase_i;
        end
        if (hit_ok) begin
            cap_coarse[hit_cnt_q] <= coarse_q;      // n-th edge after start holds n-1
            cap_phase[hit_cnt_q]  <= phase_i;
            cap_spad[hit_cnt_q]   <= spad_i;
        end
    end

    // loads fire with window_done, only for slots that got a hit
    for (genvar g = 0; g < N_SLOTS; g++) begin : g_hit
        assign hit_o[g].load        = win_done_q & (hit_cnt_q > hit_cnt_t'(g));
        assign hit_o[g].coarse      = cap_coarse[g];
        assign hit_o[g].stop_phase  = cap_phase[g];
        assign hit_o[g].start_phase = start_phase_q;
        assign hit_o[g].spad        = cap_spad[g];
    end

    assign range_o       = range_q;
    assign window_done_o = win_done_q;
    assign hit_count_o   = hit_cnt_q;
    assign busy_o        = busy_q;

endmodule

`default_nettype wire

// File: source/tdc_result_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tdc_result_if;
    import tdc_time_pkg::*;
    import tdc_stream_pkg::*;

    logic       valid;          // held until clear
    tof_t       tof;
    intensity_t intensity;
    logic       clear;          // from the streamer, beat taken

    modport src (output valid, tof, intensity, input  clear);
    modport snk (input  valid, tof, intensity, output clear);

endinterface

`default_nettype wire

// File: source/tdc_hit_if.sv
`timescale 1ns/1ps
`default_nettype none

// one captured hit, window controller to slot
interface tdc_hit_if;
    import tdc_time_pkg::*;
    import tdc_stream_pkg::*;

    logic    load;              // one cycle, fields valid with it
    coarse_t coarse;
    phase_t  stop_phase;
    phase_t  start_phase;
    spad_t   spad;

    modport src (output load, coarse, stop_phase, start_phase, spad);
    modport snk (input  load, coarse, stop_phase, start_phase, spad);

endinterface

`default_nettype wire

// File: source/tdc_stream_pkg.sv
`default_nettype none

package tdc_stream_pkg;

    // ----------------------------------------------------------------------
    // hit slots and SPAD array
    // ----------------------------------------------------------------------
    localparam int N_SLOTS = 3;                   // hits kept per window
    localparam int SPAD_N  = 16;                  // 4x4 pixel
    localparam int INT_W   = 4;

    typedef logic [SPAD_N-1:0] spad_t;

    // number of lit SPADs, capped at 15
    typedef logic [INT_W-1:0] intensity_t;

    typedef logic [$clog2(N_SLOTS+1)-1:0] hit_cnt_t;   // 0 to 3

    // ----------------------------------------------------------------------
    // output streamer
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        IDLE,       // no frame pending
        WAIT,       // window closed, slots still computing
        SEND,       // records on the stream
        DONE        // last beat taken
    } stream_state_e;

endpackage

`default_nettype wire

// File: source/tdc_time_pkg.sv
`default_nettype none

package tdc_time_pkg;

    // ----------------------------------------------------------------------
    // widths of the timing path
    // ----------------------------------------------------------------------
    localparam int PHASE_W  = 32;                 // DLL taps sampled per event
    localparam int FINE_W   = 5;
    localparam int COARSE_W = 10;
    localparam int TOF_W    = COARSE_W + FINE_W;

    // DLL phase word, a thermometer of ones starting at bit 0
    typedef logic [PHASE_W-1:0] phase_t;

    // decoded fine code, saturates at 31
    typedef logic [FINE_W-1:0] fine_t;

    typedef logic [COARSE_W-1:0] coarse_t;        // clk cycles since start

    // time of flight, the range limit uses the same format
    typedef logic [TOF_W-1:0] tof_t;

    // ----------------------------------------------------------------------
    // special codes
    // ----------------------------------------------------------------------
    localparam tof_t TOF_OVERFLOW = '1;           // out of range or no hit
    localparam tof_t RANGE_RESET  = 15'h03FC;     // coarse field 31, fine 28

endpackage

`default_nettype wire
